// ==== rtl/retire_pkg.sv ====
// Retire subsystem shared definitions

package retire_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths and fixed addresses
    ////////////////////////////////////////////////////////////////////

    localparam int          TAG_W         = 3;              // Instruction tag width
    localparam logic [31:0] TRAP_VECTOR   = 32'h0000_0100;  // Machine-mode handler entry
    localparam logic [31:0] MTIMECMP_ADDR = 32'hFFFF_0000;  // Timer compare register

    ////////////////////////////////////////////////////////////////////
    // Operation class of the retiring instruction
    ////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ALU,         // Plain register result
        OP_LB,          // Signed byte load
        OP_LBU,         // Unsigned byte load
        OP_LH,          // Signed halfword load
        OP_LHU,         // Unsigned halfword load
        OP_LW,          // Word load
        OP_STORE,
        OP_BRANCH,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET
    } instr_op_e;

    // mcause values, interrupt flag folded into its own code
    typedef enum logic [4:0] {
        EXC_NONE       = 5'd0,
        EXC_ILLEGAL    = 5'd2,
        EXC_BREAKPOINT = 5'd3,
        EXC_ECALL_M    = 5'd11,
        IRQ_MTIMER     = 5'd16
    } exc_code_e;

    // Trap controller state
    typedef enum logic {
        TS_RUN,         // Normal flow, interrupts enabled
        TS_HANDLER      // Inside trap handler, interrupts masked
    } trap_state_e;

endpackage

// ==== rtl/load_aligner.sv ====
// Load data aligner

`timescale 1ns/100ps

module load_aligner (
    input  retire_pkg::instr_op_e op_i,           // Load flavour
    input  logic [1:0]            byte_offset_i,  // Address bits 1:0
    input  logic [31:0]           mem_data_i,     // Raw word from memory
    output logic [31:0]           load_data_o     // Aligned and extended value
);

    logic [7:0]  byte_sel;    // Addressed byte
    logic [15:0] half_sel;    // Addressed halfword

    // Byte lane picked by the full offset
    assign byte_sel = mem_data_i[{byte_offset_i, 3'b000} +: 8];

    // Halfword picked by offset bit 1 only
    assign half_sel = byte_offset_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

    ////////////////////////////////////////////////////////////////////
    // Extension per load type
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            retire_pkg::OP_LB: begin
                load_data_o = {{24{byte_sel[7]}}, byte_sel};     // Sign extend
            end
            retire_pkg::OP_LBU: begin
                load_data_o = {24'h00_0000, byte_sel};           // Zero extend
            end
            retire_pkg::OP_LH: begin
                load_data_o = {{16{half_sel[15]}}, half_sel};
            end
            retire_pkg::OP_LHU: begin
                load_data_o = {16'h0000, half_sel};
            end
            default: begin
                load_data_o = mem_data_i;   // LW and non-loads pass through
            end
        endcase
    end

endmodule

// ==== rtl/retire.sv ====
// Retire stage

`timescale 1ns/100ps

module retire (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [31:0]                   result0_i,          // ALU result or store data
    input  logic [31:0]                   result1_i,          // Address or jump target
    input  logic [retire_pkg::TAG_W-1:0]  tag_i,              // Path tag of this instruction
    input  retire_pkg::instr_op_e         op_i,
    input  logic                          write_enable_i,     // Regbank write request
    input  logic [3:0]                    mem_write_enable_i, // Store byte mask
    input  logic                          jump_i,             // Taken branch or jump
    input  logic                          exception_i,        // Illegal instruction
    input  logic [31:0]                   mem_data_i,         // Load data
    input  logic                          irq_pending_i,      // Enabled interrupt waiting
    output logic                          regbank_write_enable_o,
    output logic [31:0]                   regbank_data_o,
    output logic                          jump_o,
    output logic [31:0]                   jump_target_o,
    output logic                          killed_o,
    output logic [3:0]                    mem_write_enable_o,
    output logic [31:0]                   mem_write_address_o,
    output logic [31:0]                   mem_data_o,
    output logic [retire_pkg::TAG_W-1:0]  current_tag_o,
    output logic                          raise_exception_o,
    output retire_pkg::exc_code_e         exception_code_o,
    output logic                          machine_return_o,
    output logic                          interrupt_ack_o
);

    logic [retire_pkg::TAG_W-1:0] curr_tag;     // Tag of the live path
    logic                         killed;
    logic                         is_load;
    logic [31:0]                  load_data;    // Aligned load value

    assign killed        = (tag_i != curr_tag);   // Stale path
    assign killed_o      = killed;
    assign current_tag_o = curr_tag;

    ////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////

    assign is_load = op_i inside {retire_pkg::OP_LB, retire_pkg::OP_LBU, retire_pkg::OP_LH,
                                  retire_pkg::OP_LHU, retire_pkg::OP_LW};

    load_aligner u_load_aligner (
        .op_i          (op_i),
        .byte_offset_i (result1_i[1:0]),
        .mem_data_i    (mem_data_i),
        .load_data_o   (load_data)
    );

    assign regbank_write_enable_o = write_enable_i && !killed;
    assign regbank_data_o         = is_load ? load_data : result0_i;

    ////////////////////////////////////////////////////////////////////
    // Jump and store gating
    ////////////////////////////////////////////////////////////////////

    assign jump_o        = jump_i && !killed;
    assign jump_target_o = jump_o ? result1_i : 32'h0;

    always_comb begin
        if (mem_write_enable_i != 4'b0000 && !killed) begin
            mem_write_enable_o  = mem_write_enable_i;
            mem_write_address_o = result1_i;
            mem_data_o          = result0_i;
        end else begin
            mem_write_enable_o  = 4'b0000;    // Killed or not a store
            mem_write_address_o = 32'h0;
            mem_data_o          = 32'h0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Trap decision
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        raise_exception_o = 1'b0;
        exception_code_o  = retire_pkg::EXC_NONE;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        if (!killed) begin
            if (exception_i) begin                          // Highest priority
                raise_exception_o = 1'b1;
                exception_code_o  = retire_pkg::EXC_ILLEGAL;
            end else if (op_i == retire_pkg::OP_ECALL) begin
                raise_exception_o = 1'b1;
                exception_code_o  = retire_pkg::EXC_ECALL_M;
            end else if (op_i == retire_pkg::OP_EBREAK) begin
                raise_exception_o = 1'b1;
                exception_code_o  = retire_pkg::EXC_BREAKPOINT;
            end else if (op_i == retire_pkg::OP_MRET) begin
                machine_return_o  = 1'b1;
            end else if (irq_pending_i && !jump_i) begin     // Never on top of a jump
                interrupt_ack_o   = 1'b1;
            end
        end
    end

    // New path after every control-flow change
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (jump_o || raise_exception_o || machine_return_o || interrupt_ack_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

// ==== rtl/trap_ctrl.sv ====
// Machine-mode trap controller

`timescale 1ns/100ps

module trap_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             pc_i,               // PC of retiring instruction
    input  logic                    raise_exception_i,
    input  retire_pkg::exc_code_e   exception_code_i,
    input  logic                    machine_return_i,   // MRET retired
    input  logic                    interrupt_ack_i,
    input  logic                    timer_irq_i,        // Timer level
    output logic                    irq_pending_o,      // Masked interrupt to retire
    output logic                    trap_redirect_o,    // Fetch redirect request
    output logic [31:0]             trap_target_o,
    output retire_pkg::exc_code_e   mcause_o,
    output retire_pkg::trap_state_e trap_state_o
);

    retire_pkg::trap_state_e state;
    retire_pkg::trap_state_e state_next;
    logic [31:0]             mepc;          // Return address
    retire_pkg::exc_code_e   mcause;
    logic                    mie;           // Interrupt enable
    logic                    trap_entry;    // Exception or interrupt taken

    assign mie           = (state == retire_pkg::TS_RUN);   // Masked in handler
    assign irq_pending_o = timer_irq_i && mie;
    assign trap_entry    = raise_exception_i || interrupt_ack_i;
    assign mcause_o      = mcause;
    assign trap_state_o  = state;

    ////////////////////////////////////////////////////////////////////
    // Fetch redirect, same cycle
    ////////////////////////////////////////////////////////////////////

    assign trap_redirect_o = trap_entry || machine_return_i;

    always_comb begin
        if (machine_return_i) begin
            trap_target_o = mepc;                       // Back to saved PC
        end else if (trap_entry) begin
            trap_target_o = retire_pkg::TRAP_VECTOR;
        end else begin
            trap_target_o = 32'h0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            retire_pkg::TS_RUN:     if (trap_entry)       state_next = retire_pkg::TS_HANDLER;
            retire_pkg::TS_HANDLER: if (machine_return_i) state_next = retire_pkg::TS_RUN;
            default:                state_next = retire_pkg::TS_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= retire_pkg::TS_RUN;
            mepc   <= 32'h0;
            mcause <= retire_pkg::EXC_NONE;
        end else begin
            state <= state_next;
            if (raise_exception_i) begin
                mepc   <= pc_i;                 // Re-execute faulting instruction
                mcause <= exception_code_i;
            end else if (interrupt_ack_i) begin
                mepc   <= pc_i + 32'd4;         // Interrupted instruction completes
                mcause <= retire_pkg::IRQ_MTIMER;
            end
        end
    end

endmodule

// ==== rtl/machine_timer.sv ====
// Machine timer

`timescale 1ns/100ps

module machine_timer (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  mem_write_enable_i,     // Retired store mask
    input  logic [31:0] mem_write_address_i,
    input  logic [31:0] mem_data_i,             // Store data
    output logic        timer_irq_o             // Level interrupt
);

    logic [31:0] mtime;       // Free-running counter
    logic [31:0] mtimecmp;    // Compare value
    logic        cmp_write;

    // Full-word store to the compare address only
    assign cmp_write = (mem_write_enable_i == 4'b1111)
                    && (mem_write_address_i == retire_pkg::MTIMECMP_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime    <= 32'h0;
            mtimecmp <= 32'hFFFF_FFFF;      // Never fires before first write
        end else begin
            mtime <= mtime + 32'd1;
            if (cmp_write) begin
                mtimecmp <= mem_data_i;
            end
        end
    end

    assign timer_irq_o = (mtime >= mtimecmp);   // Held until compare moves

endmodule

// ==== rtl/retire_top.sv ====
// Retire subsystem top level

`timescale 1ns/100ps

module retire_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [31:0]                   instruction_i,      // Encoded word of retiring instr
    input  logic [31:0]                   pc_i,
    input  logic [31:0]                   result0_i,
    input  logic [31:0]                   result1_i,
    input  logic [retire_pkg::TAG_W-1:0]  tag_i,
    input  retire_pkg::instr_op_e         op_i,
    input  logic                          write_enable_i,
    input  logic [3:0]                    mem_write_enable_i,
    input  logic                          jump_i,
    input  logic                          exception_i,
    input  logic [31:0]                   mem_data_i,
    output logic                          regbank_write_enable_o,
    output logic [31:0]                   regbank_data_o,
    output logic                          jump_o,
    output logic [31:0]                   jump_target_o,
    output logic                          killed_o,
    output logic [3:0]                    mem_write_enable_o,
    output logic [31:0]                   mem_write_address_o,
    output logic [31:0]                   mem_data_o,
    output logic [retire_pkg::TAG_W-1:0]  current_tag_o,
    output logic                          raise_exception_o,
    output retire_pkg::exc_code_e         exception_code_o,
    output logic                          machine_return_o,
    output logic                          interrupt_ack_o,
    output logic                          trap_redirect_o,
    output logic [31:0]                   trap_target_o,
    output retire_pkg::exc_code_e         mcause_o,
    output retire_pkg::trap_state_e       trap_state_o,
    output logic                          timer_irq_o
);

    logic irq_pending;    // Enabled interrupt, trap ctrl to retire

    retire u_retire (
        .clk                    (clk),
        .reset                  (reset),
        .result0_i              (result0_i),
        .result1_i              (result1_i),
        .tag_i                  (tag_i),
        .op_i                   (op_i),
        .write_enable_i         (write_enable_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .jump_i                 (jump_i),
        .exception_i            (exception_i),
        .mem_data_i             (mem_data_i),
        .irq_pending_i          (irq_pending),
        .regbank_write_enable_o (regbank_write_enable_o),
        .regbank_data_o         (regbank_data_o),
        .jump_o                 (jump_o),
        .jump_target_o          (jump_target_o),
        .killed_o               (killed_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_write_address_o    (mem_write_address_o),
        .mem_data_o             (mem_data_o),
        .current_tag_o          (current_tag_o),
        .raise_exception_o      (raise_exception_o),
        .exception_code_o       (exception_code_o),
        .machine_return_o       (machine_return_o),
        .interrupt_ack_o        (interrupt_ack_o)
    );

    trap_ctrl u_trap_ctrl (
        .clk               (clk),
        .reset             (reset),
        .pc_i              (pc_i),
        .raise_exception_i (raise_exception_o),
        .exception_code_i  (exception_code_o),
        .machine_return_i  (machine_return_o),
        .interrupt_ack_i   (interrupt_ack_o),
        .timer_irq_i       (timer_irq_o),
        .irq_pending_o     (irq_pending),
        .trap_redirect_o   (trap_redirect_o),
        .trap_target_o     (trap_target_o),
        .mcause_o          (mcause_o),
        .trap_state_o      (trap_state_o)
    );

    // Compare register snoops the gated store port
    machine_timer u_machine_timer (
        .clk                 (clk),
        .reset               (reset),
        .mem_write_enable_i  (mem_write_enable_o),
        .mem_write_address_i (mem_write_address_o),
        .mem_data_i          (mem_data_o),
        .timer_irq_o         (timer_irq_o)
    );

endmodule

// ==== verification/retire_assertions.sv ====
// Retire subsystem protocol assertions

`timescale 1ns/100ps

module retire_assertions (
    input logic       clk,
    input logic       reset,
    input logic       killed_i,
    input logic       regbank_write_enable_i,
    input logic       jump_i,
    input logic [3:0] mem_write_enable_i,
    input logic       raise_exception_i,
    input logic       machine_return_i,
    input logic       interrupt_ack_i,
    input logic       trap_redirect_i
);

    int fail_count = 0;     // Number of failed properties

    // Stale path leaves no side effect behind
    assert property (@(posedge clk) disable iff (reset)
        killed_i |-> (!regbank_write_enable_i && !jump_i && mem_write_enable_i == 4'b0000))
        else begin
            fail_count++;
            $error("Side effect from a killed instruction");
        end

    // One trap event per retired instruction
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({raise_exception_i, machine_return_i, interrupt_ack_i}))
        else begin
            fail_count++;
            $error("More than one trap event in the same cycle");
        end

    assert property (@(posedge clk) disable iff (reset)
        trap_redirect_i |-> (raise_exception_i || machine_return_i || interrupt_ack_i))
        else begin
            fail_count++;
            $error("Trap redirect without an exception, return or acknowledge");
        end

endmodule

bind retire_top retire_assertions u_retire_assertions (
    .clk                    (clk),
    .reset                  (reset),
    .killed_i               (killed_o),
    .regbank_write_enable_i (regbank_write_enable_o),
    .jump_i                 (jump_o),
    .mem_write_enable_i     (mem_write_enable_o),
    .raise_exception_i      (raise_exception_o),
    .machine_return_i       (machine_return_o),
    .interrupt_ack_i        (interrupt_ack_o),
    .trap_redirect_i        (trap_redirect_o)
);

// ==== verification/retire_tb.sv ====
// Retire subsystem testbench

`timescale 1ns/100ps

module retire_tb;

    localparam int CYCLE_LIMIT = 400;   // About 60 cycles of tests, generous margin

    logic clk;
    logic reset;
    logic [31:0] instruction_i, pc_i, result0_i, result1_i, mem_data_i;
    logic [retire_pkg::TAG_W-1:0] tag_i;
    retire_pkg::instr_op_e op_i;
    logic write_enable_i, jump_i, exception_i;
    logic [3:0] mem_write_enable_i;
    logic regbank_write_enable_o, jump_o, killed_o, raise_exception_o;
    logic machine_return_o, interrupt_ack_o, trap_redirect_o, timer_irq_o;
    logic [31:0] regbank_data_o, jump_target_o, mem_write_address_o, mem_data_o, trap_target_o;
    logic [3:0] mem_write_enable_o;
    logic [retire_pkg::TAG_W-1:0] current_tag_o;
    retire_pkg::exc_code_e exception_code_o, mcause_o;
    retire_pkg::trap_state_e trap_state_o;

    logic [retire_pkg::TAG_W-1:0] model_tag;    // Expected live tag
    integer seed = 32'hf9e4;
    int cycle_count = 0;

    retire_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("Errors found");
            $fatal(1, "Cycle limit reached");
        end else if (UUT.u_retire_assertions.fail_count != 0) begin
            fail_run("Bound assertion on retire_top failed");
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Check failed");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // One instruction in the cycle, outputs sampled at the falling edge
    task automatic issue(input logic [31:0] pc, input retire_pkg::instr_op_e op,
                         input logic [retire_pkg::TAG_W-1:0] tag, input logic we,
                         input logic [3:0] mask, input logic jmp, input logic exc,
                         input logic [31:0] r0, input logic [31:0] r1,
                         input logic [31:0] mdata);
        @(posedge clk);
        #5;
        pc_i               = pc;
        instruction_i      = $random(seed);
        op_i               = op;
        tag_i              = tag;
        write_enable_i     = we;
        mem_write_enable_i = mask;
        jump_i             = jmp;
        exception_i        = exc;
        result0_i          = r0;
        result1_i          = r1;
        mem_data_i         = mdata;
        @(negedge clk);
        check_value("current_tag_o", current_tag_o, model_tag);
    endtask

    task automatic bubble();    // Stale tag, so nothing retires
        issue(32'h0, retire_pkg::OP_ALU, model_tag + 1'b1, 1'b0, 4'h0, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0);
    endtask

    // Byte by full offset, halfword by offset bit 1
    function automatic logic [31:0] expected_load(input retire_pkg::instr_op_e op,
                                                  input logic [1:0] off,
                                                  input logic [31:0] word);
        logic [31:0] byte_v;
        logic [31:0] half_v;
        byte_v = (word >> (8 * off)) & 32'h0000_00FF;
        half_v = (word >> (16 * off[1])) & 32'h0000_FFFF;
        case (op)
            retire_pkg::OP_LB:  expected_load = byte_v[7] ? (byte_v | 32'hFFFF_FF00) : byte_v;
            retire_pkg::OP_LBU: expected_load = byte_v;
            retire_pkg::OP_LH:  expected_load = half_v[15] ? (half_v | 32'hFFFF_0000) : half_v;
            retire_pkg::OP_LHU: expected_load = half_v;
            default:            expected_load = word;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////

    task automatic alu_test();
        logic [31:0] data;
        data = $random(seed);
        issue(32'h1000, retire_pkg::OP_ALU, model_tag, 1'b1, 4'h0, 1'b0, 1'b0, data, 32'h0, 32'h0);
        check_value("killed_o", killed_o, 1'b0);
        check_value("regbank_write_enable_o", regbank_write_enable_o, 1'b1);
        check_value("regbank_data_o", regbank_data_o, data);
        // Stale tag asking for write, store and jump at once
        issue(32'h1004, retire_pkg::OP_ALU, model_tag + 1'b1, 1'b1, 4'hF, 1'b1, 1'b0,
              data, ~data, 32'h0);
        check_value("killed_o", killed_o, 1'b1);
        check_value("regbank_write_enable_o", regbank_write_enable_o, 1'b0);
        check_value("jump_o", jump_o, 1'b0);
        check_value("mem_write_enable_o", mem_write_enable_o, 4'h0);
    endtask

    task automatic load_test();
        retire_pkg::instr_op_e ops[5];
        logic [31:0] word;
        logic [31:0] addr;
        ops = '{retire_pkg::OP_LB, retire_pkg::OP_LBU, retire_pkg::OP_LH,
                retire_pkg::OP_LHU, retire_pkg::OP_LW};
        for (int i = 0; i < 5; i++) begin
            for (int off = 0; off < 4; off++) begin
                word = $random(seed);
                addr = {16'h0000, 14'($random(seed)), 2'(off)};
                issue(32'h2000, ops[i], model_tag, 1'b1, 4'h0, 1'b0, 1'b0, 32'h0, addr, word);
                check_value("regbank_data_o", regbank_data_o,
                            expected_load(ops[i], 2'(off), word));
            end
        end
    endtask

    task automatic store_test();
        logic [31:0] data;
        logic [31:0] addr;
        data = $random(seed);
        addr = {16'h0000, 14'($random(seed)), 2'b00};   // Clear of the timer address
        issue(32'h3000, retire_pkg::OP_STORE, model_tag, 1'b0, 4'b0110, 1'b0, 1'b0,
              data, addr, 32'h0);
        check_value("mem_write_enable_o", mem_write_enable_o, 4'b0110);
        check_value("mem_write_address_o", mem_write_address_o, addr);
        check_value("mem_data_o", mem_data_o, data);
        issue(32'h3004, retire_pkg::OP_STORE, model_tag + 1'b1, 1'b0, 4'b1111, 1'b0, 1'b0,
              data, addr, 32'h0);
        check_value("mem_write_enable_o", mem_write_enable_o, 4'h0);
        check_value("mem_write_address_o", mem_write_address_o, 32'h0);
        check_value("mem_data_o", mem_data_o, 32'h0);
    endtask

    task automatic jump_test();
        logic [31:0] target;
        target = $random(seed) & 32'hFFFF_FFFC;
        issue(32'h4000, retire_pkg::OP_BRANCH, model_tag, 1'b0, 4'h0, 1'b1, 1'b0,
              32'h0, target, 32'h0);
        check_value("jump_o", jump_o, 1'b1);
        check_value("jump_target_o", jump_target_o, target);
        check_value("trap_redirect_o", trap_redirect_o, 1'b0);
        model_tag = model_tag + 1'b1;
        // Shadow of the jump still on the old path
        issue(32'h4004, retire_pkg::OP_ALU, model_tag - 1'b1, 1'b1, 4'h0, 1'b0, 1'b0,
              32'h5, 32'h0, 32'h0);
        check_value("killed_o", killed_o, 1'b1);
        check_value("regbank_write_enable_o", regbank_write_enable_o, 1'b0);
    endtask

    task automatic trap_pair(input retire_pkg::instr_op_e op, input logic exc,
                             input retire_pkg::exc_code_e code, input logic [31:0] pc);
        issue(pc, op, model_tag, 1'b0, 4'h0, 1'b0, exc, 32'h0, 32'h0, 32'h0);
        check_value("raise_exception_o", raise_exception_o, 1'b1);
        check_value("exception_code_o", exception_code_o, code);
        check_value("trap_redirect_o", trap_redirect_o, 1'b1);
        check_value("trap_target_o", trap_target_o, retire_pkg::TRAP_VECTOR);
        model_tag = model_tag + 1'b1;
        issue(retire_pkg::TRAP_VECTOR, retire_pkg::OP_MRET, model_tag, 1'b0, 4'h0, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0);
        check_value("mcause_o", mcause_o, code);
        check_value("trap_state_o", trap_state_o, retire_pkg::TS_HANDLER);
        check_value("machine_return_o", machine_return_o, 1'b1);
        check_value("trap_target_o", trap_target_o, pc);
        model_tag = model_tag + 1'b1;
    endtask

    task automatic timer_test();
        int waited;
        waited = 0;
        issue(32'h6000, retire_pkg::OP_STORE, model_tag, 1'b0, 4'hF, 1'b0, 1'b0,
              32'h0000_0010, retire_pkg::MTIMECMP_ADDR, 32'h0);
        bubble();
        while (!timer_irq_o && waited < 8) begin
            bubble();
            waited++;
        end
        assert (timer_irq_o) else fail_run("Timer interrupt did not rise after compare write");
        issue(32'h6004, retire_pkg::OP_BRANCH, model_tag, 1'b0, 4'h0, 1'b1, 1'b0,
              32'h0, 32'h6100, 32'h0);
        check_value("interrupt_ack_o", interrupt_ack_o, 1'b0);   // Held off by the jump
        model_tag = model_tag + 1'b1;
        issue(32'h6100, retire_pkg::OP_ALU, model_tag, 1'b0, 4'h0, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0);
        check_value("interrupt_ack_o", interrupt_ack_o, 1'b1);
        check_value("trap_target_o", trap_target_o, retire_pkg::TRAP_VECTOR);
        model_tag = model_tag + 1'b1;
        issue(32'h0100, retire_pkg::OP_ALU, model_tag, 1'b0, 4'h0, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0);
        check_value("interrupt_ack_o", interrupt_ack_o, 1'b0);   // Masked in handler
        check_value("mcause_o", mcause_o, retire_pkg::IRQ_MTIMER);
        issue(32'h0104, retire_pkg::OP_MRET, model_tag, 1'b0, 4'h0, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0);
        check_value("trap_target_o", trap_target_o, 32'h6104);
        model_tag = model_tag + 1'b1;
        bubble();
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        {instruction_i, pc_i, result0_i, result1_i, mem_data_i} = '0;
        tag_i = '0;
        op_i = retire_pkg::OP_ALU;
        {write_enable_i, jump_i, exception_i} = 3'b000;
        mem_write_enable_i = 4'h0;
        model_tag = '0;
        repeat (4) @(posedge clk);
        #5 reset = 1'b0;
        alu_test();
        load_test();
        store_test();
        jump_test();
        trap_pair(retire_pkg::OP_ECALL, 1'b0, retire_pkg::EXC_ECALL_M, 32'h5000);
        trap_pair(retire_pkg::OP_EBREAK, 1'b0, retire_pkg::EXC_BREAKPOINT, 32'h5010);
        trap_pair(retire_pkg::OP_ALU, 1'b1, retire_pkg::EXC_ILLEGAL, 32'h5020);
        trap_pair(retire_pkg::OP_ECALL, 1'b1, retire_pkg::EXC_ILLEGAL, 32'h5030);
        timer_test();
        @(posedge clk);     // Last cycle's properties evaluate on this edge
        #1;
        if (UUT.u_retire_assertions.fail_count != 0) begin
            fail_run("Bound assertion on retire_top failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== retire_subsystem.f ====
rtl/retire_pkg.sv
rtl/load_aligner.sv
rtl/retire.sv
rtl/trap_ctrl.sv
rtl/machine_timer.sv
rtl/retire_top.sv
verification/retire_assertions.sv
verification/retire_tb.sv
